/* build.f */
+incdir+include
src/wbxbc_bus_pkg.sv
src/wbxbc_dist_pkg.sv
src/wbxbc_region_decoder.sv
src/wbxbc_owner_tracker.sv
src/wbxbc_response_mux.sv
src/wbxbc_distributor.sv
test/distributor_asserts.sv
test/distributor_checker.sv
test/tb_distributor.sv

/* include/wbxbc_defs.svh */
//------------------------------
// wishbone distributor sizing
// target count and bus widths
//------------------------------
`ifndef WBXBC_DEFS_SVH
`define WBXBC_DEFS_SVH

//------------------------------
// bus sizes
//------------------------------
`define WBX_TGT_CNT  4          // number of targets
`define WBX_ADR_W    16         // address width
`define WBX_DAT_W    16         // data width
`define WBX_SEL_W    2          // byte selects

//------------------------------
// ownership tracking
//------------------------------
`define WBX_PEND_W   3          // pending counter, up to 7 in flight

`endif

/* run.sh */
#!/bin/sh
# compile and run the distributor testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir

verilator --binary --timing --assert -f build.f --top-module tb_distributor \
   -o tb_distributor > build.log 2>&1
if [ $? -ne 0 ]; then
   cat build.log
   echo "compile step failed"
   exit 1
fi

./obj_dir/tb_distributor > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "^TB PASSED$" sim.log; then
   exit 0
fi
exit 1

/* src/wbxbc_bus_pkg.sv */
//------------------------------
// wishbone bus types
// request and response bundles
//------------------------------
`include "wbxbc_defs.svh"

package wbxbc_bus_pkg;

   //------------------------------
   // plain vectors
   //------------------------------
   typedef logic [`WBX_ADR_W-1:0] wb_adr_t;     // address
   typedef logic [`WBX_DAT_W-1:0] wb_dat_t;     // data word
   typedef logic [`WBX_SEL_W-1:0] wb_sel_t;     // byte selects

   //------------------------------
   // bundles
   //------------------------------
   // request fields, common to all targets
   typedef struct packed {
      logic    we;                              // write enable
      wb_sel_t sel;                             // write data selects
      wb_adr_t adr;                             // address
      wb_dat_t dat;                             // write data
   } wb_req_t;

   // response of one target
   typedef struct packed {
      logic    ack;                             // normal end of access
      logic    err;                             // access failed
      logic    rty;                             // retry later
      logic    stall;                           // request not taken
      wb_dat_t dat;                             // read data
   } wb_rsp_t;

endpackage

/* src/wbxbc_dist_pkg.sv */
//------------------------------
// distributor types
// target select, regions, owner FSM
//------------------------------
`include "wbxbc_defs.svh"

package wbxbc_dist_pkg;
   import wbxbc_bus_pkg::*;

   typedef logic [$clog2(`WBX_TGT_CNT)-1:0] tgt_idx_t;   // target number
   typedef logic [`WBX_TGT_CNT-1:0]         tgt_vec_t;   // one bit per target

   // address region of one target
   typedef struct packed {
      wb_adr_t base;                            // region base
      wb_adr_t mask;                            // relevant address bits
   } region_t;

   // ownership FSM
   typedef enum logic [1:0] {
      OWN_IDLE = 2'd0,                          // nothing pending
      OWN_BUSY = 2'd1,                          // owner has requests in flight
      OWN_ERR  = 2'd2                           // answering an unmapped access
   } owner_state_t;

endpackage

/* src/wbxbc_distributor.sv */
//------------------------------
// wishbone distributor
// one initiator to four address mapped targets
//------------------------------
`include "wbxbc_defs.svh"

module wbxbc_distributor
   import wbxbc_bus_pkg::*, wbxbc_dist_pkg::*;
(
   input  logic                       clk_i,
   input  logic                       arst_n_i,
   input  region_t [`WBX_TGT_CNT-1:0] region_i,   // static while no cycle
   input  logic                       itr_cyc_i,
   input  logic                       itr_stb_i,
   input  wb_req_t                    itr_req_i,
   output wb_rsp_t                    itr_rsp_o,
   output tgt_vec_t                   tgt_cyc_o,
   output tgt_vec_t                   tgt_stb_o,
   output wb_req_t                    tgt_req_o,  // common to all targets
   input  wb_rsp_t [`WBX_TGT_CNT-1:0] tgt_rsp_i
);

   //------------------------------
   // internal wiring
   //------------------------------
   tgt_vec_t hit;                  // decoded regions
   tgt_idx_t hit_idx;              // decoded target
   tgt_idx_t sel_idx;              // routed target
   logic     sel_vld;
   logic     switch_stall;
   logic     unmapped_err;
   logic     rsp_done;             // response back to initiator

   assign tgt_req_o = itr_req_i;   // fanout to every target

   wbxbc_region_decoder u_decoder (
      .region_i  (region_i),
      .adr_i     (itr_req_i.adr),
      .hit_o     (hit),
      .hit_idx_o (hit_idx)
   );

   wbxbc_owner_tracker u_tracker (
      .clk_i          (clk_i),
      .arst_n_i       (arst_n_i),
      .cyc_i          (itr_cyc_i),
      .stb_i          (itr_stb_i),
      .hit_i          (hit),
      .hit_idx_i      (hit_idx),
      .rsp_done_i     (rsp_done),
      .sel_idx_o      (sel_idx),
      .sel_vld_o      (sel_vld),
      .switch_stall_o (switch_stall),
      .unmapped_err_o (unmapped_err)
   );

   wbxbc_response_mux u_rsp_mux (
      .cyc_i          (itr_cyc_i),
      .stb_i          (itr_stb_i),
      .sel_idx_i      (sel_idx),
      .sel_vld_i      (sel_vld),
      .switch_stall_i (switch_stall),
      .unmapped_err_i (unmapped_err),
      .tgt_rsp_i      (tgt_rsp_i),
      .tgt_cyc_o      (tgt_cyc_o),
      .tgt_stb_o      (tgt_stb_o),
      .itr_rsp_o      (itr_rsp_o),
      .rsp_done_o     (rsp_done)
   );

endmodule

/* src/wbxbc_owner_tracker.sv */
//------------------------------
// owner tracker
// pending count per owner, switch stall, unmapped error
//------------------------------
`include "wbxbc_defs.svh"

module wbxbc_owner_tracker
   import wbxbc_dist_pkg::*;
(
   input  logic     clk_i,
   input  logic     arst_n_i,
   input  logic     cyc_i,           // initiator cycle
   input  logic     stb_i,           // initiator strobe
   input  tgt_vec_t hit_i,           // decoded regions
   input  tgt_idx_t hit_idx_i,       // decoded target
   input  logic     rsp_done_i,      // response returned this cycle
   output tgt_idx_t sel_idx_o,       // target to route to
   output logic     sel_vld_o,       // routing valid
   output logic     switch_stall_o,  // hold the request back
   output logic     unmapped_err_o   // error for unmapped access
);

   owner_state_t           state_q, state_d;
   tgt_idx_t               owner_q, owner_d;
   logic [`WBX_PEND_W-1:0] pend_q, pend_d;     // requests in flight
   logic                   mapped;             // address hits a region
   logic                   req;                // strobe inside cycle
   logic                   acc;                // request taken
   logic                   inc, dec;           // counter steps

   assign mapped = |hit_i;
   assign req    = cyc_i & stb_i;

   //------------------------------
   // stall and routing
   //------------------------------
   always_comb
   begin
      switch_stall_o = 1'b0;
      if (req)
      begin
         case (state_q)
            OWN_BUSY: switch_stall_o = ~mapped |                 // error must wait its turn
                                       (hit_idx_i != owner_q) |  // other target
                                       (&pend_q);                // counter full
            OWN_ERR:  switch_stall_o = 1'b1;                     // error slot
            default:  switch_stall_o = 1'b0;
         endcase
      end
   end

   assign acc            = req & ~switch_stall_o;
   assign inc            = acc & mapped;
   assign dec            = rsp_done_i & (state_q != OWN_ERR);   // own error is no target rsp
   assign sel_idx_o      = (state_q == OWN_BUSY) ? owner_q : hit_idx_i;
   assign sel_vld_o      = (state_q == OWN_BUSY) | (stb_i & mapped);
   assign unmapped_err_o = (state_q == OWN_ERR);                 // one cycle after acceptance

   //------------------------------
   // next state
   //------------------------------
   always_comb
   begin
      pend_d  = pend_q + {{(`WBX_PEND_W-1){1'b0}}, inc}
                       - {{(`WBX_PEND_W-1){1'b0}}, dec};
      owner_d = owner_q;
      if (inc && (state_q != OWN_BUSY))
      begin
         owner_d = hit_idx_i;                    // new owner
      end
      if (!cyc_i)
      begin
         state_d = OWN_IDLE;                     // cycle dropped, forget all
         pend_d  = '0;
      end
      else if (acc && !mapped)
      begin
         state_d = OWN_ERR;
      end
      else if (pend_d != '0)
      begin
         state_d = OWN_BUSY;
      end
      else
      begin
         state_d = OWN_IDLE;
      end
   end

   always_ff @(posedge clk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         state_q <= OWN_IDLE;
         owner_q <= '0;
         pend_q  <= '0;
      end
      else
      begin
         state_q <= state_d;
         owner_q <= owner_d;
         pend_q  <= pend_d;
      end
   end

endmodule

/* src/wbxbc_region_decoder.sv */
//------------------------------
// region decoder
// address to target hit vector and index
//------------------------------
`include "wbxbc_defs.svh"

module wbxbc_region_decoder
   import wbxbc_bus_pkg::*, wbxbc_dist_pkg::*;
(
   input  region_t [`WBX_TGT_CNT-1:0] region_i,  // base and mask per target
   input  wb_adr_t                    adr_i,     // initiator address
   output tgt_vec_t                   hit_o,     // matching regions
   output tgt_idx_t                   hit_idx_o  // encoded hit
);

   //------------------------------
   // per region compare
   //------------------------------
   always_comb
   begin
      for (int i = 0; i < `WBX_TGT_CNT; i++)
      begin
         // match when all masked bits agree with the base
         hit_o[i] = ~|((region_i[i].base ^ adr_i) & region_i[i].mask);
      end
   end

   //------------------------------
   // index encoding
   //------------------------------
   // regions never overlap, so at most one bit is set
   always_comb
   begin
      hit_idx_o = '0;                                    // unmapped reads as 0
      for (int i = 0; i < `WBX_TGT_CNT; i++)
      begin
         if (hit_o[i])
         begin
            hit_idx_o = tgt_idx_t'(i);                   // take the hit
         end
      end
   end

endmodule

/* src/wbxbc_response_mux.sv */
//------------------------------
// response mux
// target strobes out, owner response back
//------------------------------
`include "wbxbc_defs.svh"

module wbxbc_response_mux
   import wbxbc_bus_pkg::*, wbxbc_dist_pkg::*;
(
   input  logic                       cyc_i,           // initiator cycle
   input  logic                       stb_i,           // initiator strobe
   input  tgt_idx_t                   sel_idx_i,       // routed target
   input  logic                       sel_vld_i,       // routing valid
   input  logic                       switch_stall_i,  // tracker hold
   input  logic                       unmapped_err_i,  // tracker error
   input  wb_rsp_t [`WBX_TGT_CNT-1:0] tgt_rsp_i,       // target responses
   output tgt_vec_t                   tgt_cyc_o,
   output tgt_vec_t                   tgt_stb_o,
   output wb_rsp_t                    itr_rsp_o,       // merged response
   output logic                       rsp_done_o       // ack, err or rty seen
);

   wb_rsp_t sel_rsp;                                   // chosen target response
   logic    own;                                       // route is live

   assign own     = cyc_i & sel_vld_i;
   assign sel_rsp = tgt_rsp_i[sel_idx_i];

   //------------------------------
   // target side
   //------------------------------
   always_comb
   begin
      tgt_cyc_o = '0;
      tgt_stb_o = '0;
      if (own)
      begin
         tgt_cyc_o[sel_idx_i] = 1'b1;                          // only one target
         tgt_stb_o[sel_idx_i] = stb_i & ~switch_stall_i;       // held while switching
      end
   end

   //------------------------------
   // initiator side
   //------------------------------
   always_comb
   begin
      itr_rsp_o.ack   = own & sel_rsp.ack;
      itr_rsp_o.err   = (own & sel_rsp.err) | unmapped_err_i;  // own error merged
      itr_rsp_o.rty   = own & sel_rsp.rty;
      itr_rsp_o.stall = (own & sel_rsp.stall) | switch_stall_i;
      itr_rsp_o.dat   = sel_rsp.dat;                           // qualified by ack
   end

   assign rsp_done_o = itr_rsp_o.ack | itr_rsp_o.err | itr_rsp_o.rty;

endmodule

/* test/distributor_asserts.sv */
//------------------------------
// distributor assertions
//------------------------------
`include "wbxbc_defs.svh"

module distributor_asserts
   import wbxbc_bus_pkg::*, wbxbc_dist_pkg::*;
(
   input logic     clk_i,
   input logic     arst_n_i,
   input tgt_vec_t tgt_cyc_i,
   input tgt_vec_t tgt_stb_i,
   input wb_rsp_t  itr_rsp_i
);

   // one request target at a time
   a_stb_single: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      $onehot0(tgt_stb_i)) else $error("more than one target strobed");

   // one owner of the ongoing access
   a_cyc_single: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      $onehot0(tgt_cyc_i)) else $error("more than one target cycle open");

   a_rsp_single: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      $onehot0({itr_rsp_i.ack, itr_rsp_i.err, itr_rsp_i.rty}))
      else $error("initiator got several response kinds at once");

endmodule

bind wbxbc_distributor distributor_asserts u_asserts (
   .clk_i     (clk_i),
   .arst_n_i  (arst_n_i),
   .tgt_cyc_i (tgt_cyc_o),
   .tgt_stb_i (tgt_stb_o),
   .itr_rsp_i (itr_rsp_o)
);

/* test/distributor_checker.sv */
//------------------------------
// distributor checker
// request routing and response order
//------------------------------
`include "wbxbc_defs.svh"

module distributor_checker
   import wbxbc_bus_pkg::*, wbxbc_dist_pkg::*;
(
   input  logic       clk_i,
   input  logic       arst_n_i,
   input  logic       itr_cyc_i,
   input  logic       itr_stb_i,
   input  wb_req_t    itr_req_i,
   input  wb_rsp_t    itr_rsp_i,
   input  tgt_vec_t   tgt_cyc_i,
   input  tgt_vec_t   tgt_stb_i,
   input  wb_req_t    tgt_req_i,
   input  logic [2:0] exp_tgt_i,      // 4 means unmapped
   input  logic       exp_kind_i,     // 0 ack, 1 err
   input  wb_dat_t    exp_rdat_i,
   input  logic [1:0] exp_chain_i,    // 1 must be taken before any answer
   output int         err_cnt_o,
   output int         rsp_cnt_o
);

   int      cyc_cnt   = 0;
   int      chain_rsp = 0;            // answers since cycle start
   int      errs      = 0;
   int      rsps      = 0;
   logic    kind_q [$];
   logic    we_q   [$];
   wb_dat_t rdat_q [$];
   int      acc_q  [$];               // cycle of acceptance

   function automatic tgt_vec_t one_hot(input logic [2:0] tgt);
      tgt_vec_t v;
      v = '0;
      if (tgt < 3'd4)
      begin
         v[tgt[1:0]] = 1'b1;
      end
      return v;
   endfunction

   task automatic compare_value(input string name, input logic [31:0] exp,
                                input logic [31:0] got);
      if (exp !== got)
      begin
         $display("[FAIL] %s: expected %h, got %h", name, exp, got);
         errs++;
      end
   endtask

   //------------------------------
   // response side
   //------------------------------
   task automatic check_response();
      logic    kind;
      logic    we;
      wb_dat_t rdat;
      int      acc;
      if (itr_rsp_i.ack || itr_rsp_i.err || itr_rsp_i.rty)
      begin
         rsps++;
         chain_rsp++;
         if (kind_q.size() == 0)
         begin
            $display("response arrived with no request pending");
            errs++;
         end
         else
         begin
            kind = kind_q.pop_front();
            we   = we_q.pop_front();
            rdat = rdat_q.pop_front();
            acc  = acc_q.pop_front();
            compare_value("itr_rsp_o.ack_err_rty", 32'(kind ? 3'b010 : 3'b100),
                          32'({itr_rsp_i.ack, itr_rsp_i.err, itr_rsp_i.rty}));
            if (!kind && !we)
            begin
               compare_value("itr_rsp_o.dat", 32'(rdat), 32'(itr_rsp_i.dat));
            end
            if (kind)
            begin
               compare_value("itr_rsp_o.err_cycle", acc + 1, cyc_cnt);  // next cycle
            end
         end
      end
   endtask

   //------------------------------
   // request side
   //------------------------------
   task automatic check_request();
      tgt_vec_t stb_exp;
      stb_exp = itr_rsp_i.stall ? '0 : one_hot(exp_tgt_i);  // held back while stalled
      if (exp_chain_i != 2'd2)
      begin
         compare_value("itr_rsp_o.stall", 32'h0, 32'(itr_rsp_i.stall));  // same owner or idle
      end
      compare_value("tgt_stb_o", 32'(stb_exp), 32'(tgt_stb_i));
      if (!itr_rsp_i.stall)
      begin
         compare_value("tgt_cyc_o", 32'(one_hot(exp_tgt_i)), 32'(tgt_cyc_i));
         compare_value("tgt_req_o.adr", 32'(itr_req_i.adr), 32'(tgt_req_i.adr));
         compare_value("tgt_req_o.dat", 32'(itr_req_i.dat), 32'(tgt_req_i.dat));
         compare_value("tgt_req_o.we_sel", 32'({itr_req_i.we, itr_req_i.sel}),
                       32'({tgt_req_i.we, tgt_req_i.sel}));
         if (exp_chain_i == 2'd0)
         begin
            chain_rsp = 0;
         end
         else if (exp_chain_i == 2'd1 && chain_rsp != 0)
         begin
            $display("pipelined request was taken only after a response came back");
            errs++;
         end
         else if (exp_chain_i == 2'd2 &&
                  (kind_q.size() != 0 || itr_rsp_i.ack || itr_rsp_i.err || itr_rsp_i.rty))
         begin
            $display("queued request was sent before the owner had answered all requests");
            errs++;
         end
         kind_q.push_back(exp_kind_i);
         we_q.push_back(itr_req_i.we);
         rdat_q.push_back(exp_rdat_i);
         acc_q.push_back(cyc_cnt);
      end
   endtask

   always @(posedge clk_i)
   begin
      cyc_cnt = cyc_cnt + 1;
      // no cycle, also during reset, means a quiet bus
      if (!itr_cyc_i)
      begin
         compare_value("tgt_cyc_o", 32'h0, 32'(tgt_cyc_i));
         compare_value("tgt_stb_o", 32'h0, 32'(tgt_stb_i));
         compare_value("itr_rsp_o.ctrl", 32'h0, 32'({itr_rsp_i.ack, itr_rsp_i.err,
                                                     itr_rsp_i.rty, itr_rsp_i.stall}));
      end
      else if (arst_n_i)
      begin
         check_response();                      // older requests first
         if (itr_stb_i)
         begin
            check_request();
         end
      end
      err_cnt_o <= errs;
      rsp_cnt_o <= rsps;
   end

endmodule

/* test/distributor_stim.txt */
# R base mask : one region per target, targets 0 to 3 in order, hex
# T we adr wdat dly rdat tgt kind chain : tgt 4 unmapped, kind 0 ack 1 err
# chain 0 opens a cycle, 1 pipelined behind it, 2 queued behind the owner
R 0000 C000
R 4000 C000
R 8000 E000
R C000 C000
T 1 0010 1234 2 0000 0 0 0
T 0 0012 0000 1 BEEF 0 0 0
T 0 4100 0000 3 CAFE 1 0 0
T 1 8020 5A5A 1 0000 2 0 0
T 0 A000 0000 0 0000 4 1 0
T 1 C004 0F0F 2 0000 3 0 0
T 0 4000 0000 5 1111 1 0 0
T 0 4002 0000 5 2222 1 0 1
T 1 4004 00AA 5 0000 1 0 1
T 0 0100 0000 4 4444 0 0 0
T 0 8100 0000 1 5555 2 0 2
T 0 B234 0000 0 0000 4 1 0
T 0 C0F0 0000 2 6666 3 0 0

/* test/tb_distributor.sv */
//------------------------------
// distributor testbench
// stim file driven, four target models
//------------------------------
`include "wbxbc_defs.svh"

module tb_distributor
   import wbxbc_bus_pkg::*, wbxbc_dist_pkg::*;
;

   localparam int MAX_TXN = 32;

   logic                       clk;
   logic                       arst_n;
   region_t [`WBX_TGT_CNT-1:0] region;
   logic                       itr_cyc;
   logic                       itr_stb;
   wb_req_t                    itr_req;
   wb_rsp_t                    itr_rsp;
   tgt_vec_t                   tgt_cyc;
   tgt_vec_t                   tgt_stb;
   wb_req_t                    tgt_req;
   wb_rsp_t [`WBX_TGT_CNT-1:0] tgt_rsp;

   // expected values that travel with each request
   logic [2:0] exp_tgt;                         // 4 means unmapped
   logic       exp_kind;                        // 0 ack, 1 err
   wb_dat_t    exp_rdat;
   logic [1:0] exp_chain;
   logic [7:0] cur_dly;                         // target answer delay

   // stim table
   logic       we_a    [MAX_TXN];
   wb_adr_t    adr_a   [MAX_TXN];
   wb_dat_t    wdat_a  [MAX_TXN];
   logic [7:0] dly_a   [MAX_TXN];
   wb_dat_t    rdat_a  [MAX_TXN];
   logic [2:0] tgt_a   [MAX_TXN];
   logic       kind_a  [MAX_TXN];
   logic [1:0] chain_a [MAX_TXN];

   int n_reg;
   int n_txn;
   int seed;
   int issued;                                  // accepted requests
   int tmo_cnt;
   int setup_err;
   int err_cnt;
   int rsp_cnt;
   int idx;
   int gap;

   // target model state, one in-order queue is enough
   // since only one target owns requests at a time
   int         mcyc;
   int         last_due;
   int         due_q [$];
   logic [1:0] tq    [$];
   wb_dat_t    dq    [$];

   //------------------------------
   // clock, DUT, checker
   //------------------------------
   always #10 clk = ~clk;                        // period 20

   wbxbc_distributor uut (
      .clk_i     (clk),
      .arst_n_i  (arst_n),
      .region_i  (region),
      .itr_cyc_i (itr_cyc),
      .itr_stb_i (itr_stb),
      .itr_req_i (itr_req),
      .itr_rsp_o (itr_rsp),
      .tgt_cyc_o (tgt_cyc),
      .tgt_stb_o (tgt_stb),
      .tgt_req_o (tgt_req),
      .tgt_rsp_i (tgt_rsp)
   );

   distributor_checker u_chk (
      .clk_i       (clk),
      .arst_n_i    (arst_n),
      .itr_cyc_i   (itr_cyc),
      .itr_stb_i   (itr_stb),
      .itr_req_i   (itr_req),
      .itr_rsp_i   (itr_rsp),
      .tgt_cyc_i   (tgt_cyc),
      .tgt_stb_i   (tgt_stb),
      .tgt_req_i   (tgt_req),
      .exp_tgt_i   (exp_tgt),
      .exp_kind_i  (exp_kind),
      .exp_rdat_i  (exp_rdat),
      .exp_chain_i (exp_chain),
      .err_cnt_o   (err_cnt),
      .rsp_cnt_o   (rsp_cnt)
   );

   //------------------------------
   // target models
   //------------------------------
   always @(posedge clk or negedge arst_n)
   begin
      int due;
      if (!arst_n)
      begin
         tgt_rsp  <= '0;
         mcyc     = 0;
         last_due = 0;
      end
      else
      begin
         mcyc = mcyc + 1;
         tgt_rsp <= '0;                          // ack lasts one cycle
         if (due_q.size() > 0 && due_q[0] <= mcyc)
         begin
            tgt_rsp[tq[0]].ack <= 1'b1;
            tgt_rsp[tq[0]].dat <= dq[0];
            void'(due_q.pop_front());
            void'(tq.pop_front());
            void'(dq.pop_front());
         end
         for (int t = 0; t < `WBX_TGT_CNT; t++)
         begin
            if (tgt_cyc[2'(t)] && tgt_stb[2'(t)])
            begin
               due = mcyc + int'(cur_dly);
               if (due <= last_due)
               begin
                  due = last_due + 1;            // keep answers in order
               end
               last_due = due;
               due_q.push_back(due);
               tq.push_back(2'(t));
               dq.push_back(exp_rdat);
            end
         end
      end
   end

   //------------------------------
   // stim file
   //------------------------------
   task automatic read_stim();
      int          fd;
      int          code;
      string       line;
      logic [31:0] fld [8];
      fd = $fopen("test/distributor_stim.txt", "r");
      if (fd == 0)
      begin
         $display("stim file could not be opened");
         setup_err++;
      end
      else
      begin
         while (!$feof(fd))
         begin
            code = $fgets(line, fd);
            if (code > 0 && line.getc(0) == "R" && n_reg < `WBX_TGT_CNT)
            begin
               code = $sscanf(line, "R %h %h", fld[0], fld[1]);
               region[2'(n_reg)].base = fld[0][15:0];
               region[2'(n_reg)].mask = fld[1][15:0];
               n_reg++;
            end
            else if (code > 0 && line.getc(0) == "T" && n_txn < MAX_TXN)
            begin
               code = $sscanf(line, "T %h %h %h %h %h %h %h %h", fld[0], fld[1],
                              fld[2], fld[3], fld[4], fld[5], fld[6], fld[7]);
               if (code != 8)
               begin
                  $display("malformed transaction line in stim file");
                  setup_err++;
               end
               else
               begin
                  we_a[n_txn]    = fld[0][0];
                  adr_a[n_txn]   = fld[1][15:0];
                  wdat_a[n_txn]  = fld[2][15:0];
                  dly_a[n_txn]   = fld[3][7:0];
                  rdat_a[n_txn]  = fld[4][15:0];
                  tgt_a[n_txn]   = fld[5][2:0];
                  kind_a[n_txn]  = fld[6][0];
                  chain_a[n_txn] = fld[7][1:0];
                  n_txn++;
               end
            end
         end
         $fclose(fd);
         if (n_reg != `WBX_TGT_CNT || n_txn == 0)
         begin
            $display("stim file lacks regions or transactions");
            setup_err++;
         end
      end
   endtask

   //------------------------------
   // initiator
   //------------------------------
   // drive one request and wait until it is taken
   task automatic issue(input int i);
      int      wait_cnt;
      wb_req_t req;
      wait_cnt = 0;
      req.we   = we_a[i];
      req.sel  = 2'b11;
      req.adr  = adr_a[i];
      req.dat  = wdat_a[i];
      itr_stb   <= 1'b1;
      itr_req   <= req;
      exp_tgt   <= tgt_a[i];
      exp_kind  <= kind_a[i];
      exp_rdat  <= rdat_a[i];
      exp_chain <= chain_a[i];
      cur_dly   <= dly_a[i];
      do
      begin
         @(posedge clk);
         wait_cnt++;
      end
      while (itr_rsp.stall && wait_cnt < 50);
      if (itr_rsp.stall)
      begin
         $display("timeout: request %0d was never accepted", i);
         tmo_cnt++;
      end
      else
      begin
         issued++;
      end
   endtask

   task automatic wait_responses();
      int wait_cnt;
      wait_cnt = 0;
      while (rsp_cnt < issued && wait_cnt < 100)
      begin
         @(posedge clk);
         wait_cnt++;
      end
      if (rsp_cnt < issued)
      begin
         $display("timeout: %0d responses still missing", issued - rsp_cnt);
         tmo_cnt++;
      end
   endtask

   // one bus cycle, a line plus its chained followers
   task automatic run_group(inout int i);
      itr_cyc <= 1'b1;
      issue(i);
      i++;
      while (i < n_txn && chain_a[i] != 2'd0 && tmo_cnt == 0)
      begin
         issue(i);
         i++;
      end
      itr_stb <= 1'b0;
      wait_responses();
      itr_cyc <= 1'b0;                           // close cycle
      @(posedge clk);
   endtask

   initial
   begin
      seed      = 30291;
      n_reg     = 0;
      n_txn     = 0;
      issued    = 0;
      tmo_cnt   = 0;
      setup_err = 0;
      clk       = 1'b0;
      arst_n    = 1'b0;
      region    = '0;
      itr_cyc   = 1'b0;
      itr_stb   = 1'b0;
      itr_req   = '0;
      exp_tgt   = 3'd4;
      exp_kind  = 1'b0;
      exp_rdat  = '0;
      exp_chain = 2'd0;
      cur_dly   = 8'd1;
      read_stim();                               // regions set while in reset
      repeat (16) @(posedge clk);
      arst_n <= 1'b1;
      repeat (2) @(posedge clk);
      idx = 0;
      while (idx < n_txn && tmo_cnt == 0)
      begin
         gap = int'($unsigned($random(seed)) % 32'd4);
         repeat (gap) @(posedge clk);            // idle between cycles
         run_group(idx);
      end
      repeat (4) @(posedge clk);
      $display("errors: %0d check, %0d timeout, %0d setup", err_cnt, tmo_cnt, setup_err);
      if (err_cnt == 0 && tmo_cnt == 0 && setup_err == 0 && idx == n_txn)
      begin
         $display("TB PASSED");
      end
      else
      begin
         $display("TB FAILED");
      end
      $finish;
   end

endmodule
